// File: source/access_pkg.sv
package access_pkg;

	// Pixel geometry of the up-sampler output
	localparam int PIXEL_BITS      = 24;
	localparam int PIXELS_PER_BEAT = 4;

	typedef logic [PIXEL_BITS-1:0] pixel_t;

	// Element 0 is the first pixel in up-sampler order
	typedef pixel_t [PIXELS_PER_BEAT-1:0] pix_beat_t;

	// One beat on the stream master port
	typedef struct packed {
		pix_beat_t data;
		logic      last;
	} axis_beat_t;

	// Control word of the configuration register file
	typedef struct packed {
		logic upend;
		logic upstart;
	} ctrl_bits_t;

	// Frame sequencing states
	typedef enum logic [1:0] {
		IDLE,
		ACTIVE,
		CLEAR_START,
		SET_END
	} run_state_e;

endpackage

// File: source/run_control.sv
module run_control import access_pkg::*; (
	input  logic       clk,
	input  logic       rst_n,
	input  ctrl_bits_t crf_ctrl,
	input  logic       frame_done,
	output logic       window,
	output logic       crf_wr,
	output ctrl_bits_t crf_wdata,
	output logic       up_reset
);

	run_state_e state;

	logic start_req;
	logic frame_end;
	logic ctrl_clear;
	logic end_seen;

	// Decoded views of the register file control word
	assign start_req  = crf_ctrl.upstart && !crf_ctrl.upend;
	assign ctrl_clear = !crf_ctrl.upstart && !crf_ctrl.upend;
	assign end_seen   = crf_ctrl.upend && !crf_ctrl.upstart;

	// Only a running frame can end
	assign frame_end = (state == ACTIVE) && frame_done;

	// The up-sampler may only write while a frame is running
	assign window = (state == ACTIVE);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state    <= IDLE;
			crf_wr   <= 1'b0;
			up_reset <= 1'b0;
		end else begin
			crf_wr   <= 1'b0;
			up_reset <= 1'b0;
			case (state)
				IDLE: begin
					if (start_req) begin
						state <= ACTIVE;
					end
				end
				ACTIVE: begin
					// Clear UPSTART and reset the up-sampler for the next frame
					if (frame_end) begin
						state    <= CLEAR_START;
						crf_wr   <= 1'b1;
						up_reset <= 1'b1;
					end
				end
				CLEAR_START: begin
					// Wait until the clear has landed in the register file
					if (ctrl_clear) begin
						state  <= SET_END;
						crf_wr <= 1'b1;
					end
				end
				SET_END: begin
					if (end_seen) begin
						state <= IDLE;
					end
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	// Data of the two end-of-frame register writes
	always_ff @(posedge clk) begin
		if (frame_end) begin
			crf_wdata <= '{upend: crf_ctrl.upend, upstart: 1'b0};
		end else if (state == CLEAR_START && ctrl_clear) begin
			crf_wdata <= '{upend: 1'b1, upstart: 1'b0};
		end
	end

	// Write-backs belong to the end sequence only
	a_no_wr_outside_end: assert property (
		@(posedge clk) disable iff (!rst_n)
		(state inside {IDLE, ACTIVE}) |-> !crf_wr
	);

	// Up-sampler reset is a single cycle pulse
	a_up_reset_pulse: assert property (
		@(posedge clk) disable iff (!rst_n)
		up_reset |=> !up_reset
	);

endmodule

// File: source/pixel_fifo.sv
module pixel_fifo import access_pkg::*; #(
	parameter int DEPTH = 4
) (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      flush,
	input  logic      window,
	input  logic      wr_valid,
	input  pix_beat_t wr_beat,
	output logic      wr_ready,
	input  logic      rd,
	output pix_beat_t head,
	output logic      empty
);

	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CW = $clog2(DEPTH + 1);

	pix_beat_t mem [DEPTH];

	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [CW-1:0] count;
	logic          full;
	logic          wr_en;

	// Pointer advance with wrap for any depth
	function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] ptr);
		if (ptr == AW'(DEPTH - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	assign full     = (count == CW'(DEPTH));
	assign empty    = (count == '0);
	assign wr_ready = window && !full;
	assign wr_en    = wr_valid && wr_ready;
	assign head     = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem[wr_ptr] <= wr_beat;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else if (flush) begin
			// Frame end drops anything left over
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr_en) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (rd) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			case ({wr_en, rd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// The packer must never pop an empty buffer
	a_no_pop_empty: assert property (
		@(posedge clk) disable iff (!rst_n)
		rd |-> !empty
	);

	a_count_bound: assert property (
		@(posedge clk) disable iff (!rst_n)
		count <= CW'(DEPTH)
	);

endmodule

// File: source/stream_packer.sv
module stream_packer import access_pkg::*; #(
	parameter int DST_WIDTH  = 16,
	parameter int DST_HEIGHT = 3
) (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       window,
	input  logic       empty,
	input  pix_beat_t  head,
	output logic       rd,
	output logic       m_valid,
	output axis_beat_t m_beat,
	input  logic       m_ready,
	output logic       frame_done
);

	localparam int BEATS_PER_ROW = DST_WIDTH / PIXELS_PER_BEAT;
	localparam int BW = (BEATS_PER_ROW > 1) ? $clog2(BEATS_PER_ROW) : 1;
	localparam int RW = (DST_HEIGHT > 1) ? $clog2(DST_HEIGHT) : 1;

	if (DST_WIDTH % PIXELS_PER_BEAT != 0) begin : g_width_check
		$error("DST_WIDTH must be a multiple of PIXELS_PER_BEAT");
	end

	logic [BW-1:0] beat_cnt;
	logic [RW-1:0] row_cnt;
	logic          row_end;
	logic          accept;
	pix_beat_t     swapped;

	// Pop when there is room in the output register
	assign rd = !empty && window && (!m_valid || m_ready);

	assign accept     = m_valid && m_ready;
	assign row_end    = (beat_cnt == BW'(BEATS_PER_ROW - 1));
	assign frame_done = accept && m_beat.last && (row_cnt == RW'(DST_HEIGHT - 1));

	// Stream order is the reverse of the up-sampler pixel order
	always_comb begin
		for (int i = 0; i < PIXELS_PER_BEAT; i++) begin
			swapped[i] = head[PIXELS_PER_BEAT-1-i];
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			m_valid <= 1'b0;
		end else if (rd) begin
			m_valid <= 1'b1;
		end else if (m_ready) begin
			m_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (rd) begin
			m_beat.data <= swapped;
			m_beat.last <= row_end;
		end
	end

	// Beat position in the row advances on every pop
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			beat_cnt <= '0;
		end else if (frame_done) begin
			beat_cnt <= '0;
		end else if (rd) begin
			beat_cnt <= row_end ? '0 : beat_cnt + 1'b1;
		end
	end

	// Rows are counted on the accepted last beat
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			row_cnt <= '0;
		end else if (frame_done) begin
			row_cnt <= '0;
		end else if (accept && m_beat.last) begin
			row_cnt <= row_cnt + 1'b1;
		end
	end

	// A waiting beat must not move
	a_hold_beat: assert property (
		@(posedge clk) disable iff (!rst_n)
		(m_valid && !m_ready) |=> (m_valid && $stable(m_beat))
	);

endmodule

// File: source/access_control.sv
module access_control import access_pkg::*; #(
	parameter int DST_WIDTH  = 4096,
	parameter int DST_HEIGHT = 2160,
	parameter int FIFO_DEPTH = 32
) (
	input  logic       clk,
	input  logic       rst_n,
	input  ctrl_bits_t crf_ctrl,
	output logic       crf_wr,
	output ctrl_bits_t crf_wdata,
	output logic       up_reset,
	input  logic       pix_valid,
	input  pix_beat_t  pix_in,
	output logic       pix_ready,
	output logic       m_valid,
	output axis_beat_t m_beat,
	input  logic       m_ready
);

	logic      window;
	logic      frame_done;
	logic      rd;
	logic      empty;
	pix_beat_t head;

	run_control u_run_control (
		.clk       (clk),
		.rst_n     (rst_n),
		.crf_ctrl  (crf_ctrl),
		.frame_done(frame_done),
		.window    (window),
		.crf_wr    (crf_wr),
		.crf_wdata (crf_wdata),
		.up_reset  (up_reset)
	);

	// Frame end flushes the buffer
	pixel_fifo #(
		.DEPTH(FIFO_DEPTH)
	) u_pixel_fifo (
		.clk     (clk),
		.rst_n   (rst_n),
		.flush   (frame_done),
		.window  (window),
		.wr_valid(pix_valid),
		.wr_beat (pix_in),
		.wr_ready(pix_ready),
		.rd      (rd),
		.head    (head),
		.empty   (empty)
	);

	stream_packer #(
		.DST_WIDTH (DST_WIDTH),
		.DST_HEIGHT(DST_HEIGHT)
	) u_stream_packer (
		.clk       (clk),
		.rst_n     (rst_n),
		.window    (window),
		.empty     (empty),
		.head      (head),
		.rd        (rd),
		.m_valid   (m_valid),
		.m_beat    (m_beat),
		.m_ready   (m_ready),
		.frame_done(frame_done)
	);

endmodule

// File: sim/access_control_tb.sv
module access_control_tb import access_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int DST_WIDTH       = 16;
	localparam int DST_HEIGHT      = 3;
	localparam int FIFO_DEPTH      = 4;
	localparam int BEATS_PER_ROW   = DST_WIDTH / PIXELS_PER_BEAT;
	localparam int BEATS_PER_FRAME = BEATS_PER_ROW * DST_HEIGHT;

	// Three frames, up to 4 cycles per beat with random stalls, plus the end handshakes
	localparam int FRAME_RUNS        = 3;
	localparam int WORST_BEAT_CYCLES = 4;
	localparam int HANDSHAKE_CYCLES  = 50;
	localparam int TIMEOUT_CYCLES    =
		5 * (FRAME_RUNS * (BEATS_PER_FRAME * WORST_BEAT_CYCLES + HANDSHAKE_CYCLES)) + 30;

	localparam ctrl_bits_t CTRL_CLEARED = '{upend: 1'b0, upstart: 1'b0};
	localparam ctrl_bits_t CTRL_ENDED   = '{upend: 1'b1, upstart: 1'b0};

	logic       clk;
	logic       rst_n;
	ctrl_bits_t crf_ctrl = '0;
	logic       crf_wr;
	ctrl_bits_t crf_wdata;
	logic       up_reset;
	logic       pix_valid;
	pix_beat_t  pix_in;
	logic       pix_ready;
	logic       m_valid;
	axis_beat_t m_beat;
	logic       m_ready;

	// Host side of the register file
	logic       host_wr;
	ctrl_bits_t host_wdata;
	logic       host_wr_seen;
	logic       rf_wr_seen;
	ctrl_bits_t rf_data_seen;

	ctrl_bits_t wr_log [$];
	int         reset_pulses = 0;
	int         reset_cycle = 0;
	int         last_accept_cycle = 0;
	int         base_writes = 0;
	int         base_resets = 0;
	int         cycle_count = 0;
	int         mismatch_count = 0;
	int         failure_count = 0;
	integer     seed = 82;
	pix_beat_t  frame_beats [BEATS_PER_FRAME];

	access_control #(
		.DST_WIDTH (DST_WIDTH),
		.DST_HEIGHT(DST_HEIGHT),
		.FIFO_DEPTH(FIFO_DEPTH)
	) DUT (
		.clk      (clk),
		.rst_n    (rst_n),
		.crf_ctrl (crf_ctrl),
		.crf_wr   (crf_wr),
		.crf_wdata(crf_wdata),
		.up_reset (up_reset),
		.pix_valid(pix_valid),
		.pix_in   (pix_in),
		.pix_ready(pix_ready),
		.m_valid  (m_valid),
		.m_beat   (m_beat),
		.m_ready  (m_ready)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// A register file write lands on the next edge and DUT write-backs win over the host
	always begin
		@(negedge clk);
		rf_wr_seen   = crf_wr;
		rf_data_seen = crf_wdata;
		host_wr_seen = host_wr;
		if (crf_wr) begin
			wr_log.push_back(crf_wdata);
		end
		if (up_reset) begin
			reset_pulses++;
			reset_cycle = cycle_count;
		end
		@(posedge clk);
		#1;
		if (rf_wr_seen) begin
			crf_ctrl = rf_data_seen;
		end else if (host_wr_seen) begin
			crf_ctrl = host_wdata;
		end
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	task automatic check_beat(input string name, input axis_beat_t got, input axis_beat_t exp);
		if (got !== exp) begin
			$display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
			mismatch_count++;
		end
	endtask

	task automatic check_ctrl(input string name, input ctrl_bits_t got, input ctrl_bits_t exp);
		if (got !== exp) begin
			$display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
			mismatch_count++;
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
			mismatch_count++;
		end
	endtask

	// The first up-sampler pixel goes out last and last closes each row
	function automatic axis_beat_t expected_out(input pix_beat_t px, input int index);
		axis_beat_t beat;
		for (int p = 0; p < PIXELS_PER_BEAT; p++) begin
			beat.data[PIXELS_PER_BEAT-1-p] = px[p];
		end
		beat.last = ((index + 1) % BEATS_PER_ROW) == 0;
		return beat;
	endfunction

	task automatic make_frame;
		for (int i = 0; i < BEATS_PER_FRAME; i++) begin
			for (int p = 0; p < PIXELS_PER_BEAT; p++) begin
				frame_beats[i][p] = pixel_t'($random(seed));
			end
		end
	endtask

	task automatic start_frame;
		base_writes = wr_log.size();
		base_resets = reset_pulses;
		host_wdata  = '{upend: 1'b0, upstart: 1'b1};
		host_wr     = 1'b1;
		@(posedge clk);
		#1;
		host_wr = 1'b0;
	endtask

	task automatic send_frame;
		logic taken;
		for (int i = 0; i < BEATS_PER_FRAME; i++) begin
			pix_valid = 1'b1;
			pix_in    = frame_beats[i];
			do begin
				@(negedge clk);
				taken = pix_ready;
				@(posedge clk);
				#1;
			end while (!taken);
		end
		pix_valid = 1'b0;
	endtask

	task automatic collect_frame(input bit stall);
		int         got;
		logic       waiting;
		axis_beat_t held;
		got     = 0;
		waiting = 1'b0;
		while (got < BEATS_PER_FRAME) begin
			m_ready = stall ? (($random(seed) & 1) != 0) : 1'b1;
			@(negedge clk);
			// A beat left waiting must still be there unchanged
			if (waiting) begin
				check_bit("m_valid", m_valid, 1'b1);
				check_beat("m_beat (held)", m_beat, held);
			end
			waiting = m_valid && !m_ready;
			held    = m_beat;
			if (m_valid && m_ready) begin
				check_beat("m_beat", m_beat, expected_out(frame_beats[got], got));
				last_accept_cycle = cycle_count;
				got++;
			end
			@(posedge clk);
			#1;
		end
		m_ready = 1'b1;
	endtask

	task automatic wait_end_report;
		do begin
			@(negedge clk);
		end while (!(crf_ctrl.upend && !crf_ctrl.upstart));
		repeat (2) @(posedge clk);
		#1;
	endtask

	task automatic check_end_sequence;
		int writes;
		int pulses;
		writes = wr_log.size() - base_writes;
		pulses = reset_pulses - base_resets;
		if (pulses != 1) begin
			$display("up_reset pulsed %0d times at frame end instead of once", pulses);
			failure_count++;
		end else if (reset_cycle != last_accept_cycle + 1) begin
			$display("up_reset came %0d cycles after the last beat instead of one",
				reset_cycle - last_accept_cycle);
			failure_count++;
		end
		if (writes != 2) begin
			$display("saw %0d register writes at frame end instead of two", writes);
			failure_count++;
		end else begin
			check_ctrl("crf_wdata (first write)", wr_log[base_writes], CTRL_CLEARED);
			check_ctrl("crf_wdata (second write)", wr_log[base_writes+1], CTRL_ENDED);
		end
	endtask

	task automatic reset_state_test;
		pix_valid = 1'b1;
		pix_in    = '1;
		repeat (4) begin
			@(negedge clk);
			check_bit("crf_wr", crf_wr, 1'b0);
			check_bit("up_reset", up_reset, 1'b0);
			check_bit("m_valid", m_valid, 1'b0);
			check_bit("pix_ready", pix_ready, 1'b0);
			@(posedge clk);
			#1;
		end
		pix_valid = 1'b0;
	endtask

	task automatic frame_transfer_test;
		start_frame();
		make_frame();
		fork
			send_frame();
			collect_frame(1'b0);
		join
		wait_end_report();
	endtask

	task automatic back_pressure_test;
		start_frame();
		make_frame();
		fork
			send_frame();
			collect_frame(1'b1);
		join
	endtask

	task automatic end_handshake_test;
		wait_end_report();
		check_end_sequence();
		// Window stays closed once the frame has ended
		pix_valid = 1'b1;
		repeat (4) begin
			@(negedge clk);
			check_bit("pix_ready", pix_ready, 1'b0);
			check_bit("m_valid", m_valid, 1'b0);
			@(posedge clk);
			#1;
		end
		pix_valid = 1'b0;
	endtask

	task automatic restart_test;
		start_frame();
		make_frame();
		fork
			send_frame();
			collect_frame(1'b0);
		join
		wait_end_report();
		check_end_sequence();
	endtask

	initial begin
		rst_n      = 1'b0;
		host_wr    = 1'b0;
		host_wdata = '0;
		pix_valid  = 1'b0;
		pix_in     = '0;
		m_ready    = 1'b0;
		repeat (2) @(posedge clk);
		#1;
		rst_n = 1'b1;
		reset_state_test();
		frame_transfer_test();
		back_pressure_test();
		end_handshake_test();
		restart_test();
		$display("errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
		if (mismatch_count == 0 && failure_count == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

// File: build.f
source/access_pkg.sv
source/run_control.sv
source/pixel_fifo.sv
source/stream_packer.sv
source/access_control.sv
sim/access_control_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the access_control testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=access_control_sim

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module access_control_tb -f build.f -Mdir obj_dir -o "$BIN"
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "TESTBENCH FAILED" "$LOG"; then
	exit 1
fi
exit 0
